// ==== Bender.yml ====
package:
  name: au_subsystem

sources:
  - verilog/au_defs_pkg.sv
  - verilog/slice_pkg.sv
  - verilog/slice_sequencer.sv
  - verilog/au_decode.sv
  - verilog/au_execute.sv
  - verilog/au_retire.sv
  - verilog/slice_regfile.sv
  - verilog/au_subsystem_top.sv
  - target: test
    files:
      - tests/au_subsystem_asserts.sv
      - tests/tb_au_subsystem.sv

// ==== flist.f ====
verilog/au_defs_pkg.sv
verilog/slice_pkg.sv
verilog/slice_sequencer.sv
verilog/au_decode.sv
verilog/au_execute.sv
verilog/au_retire.sv
verilog/slice_regfile.sv
verilog/au_subsystem_top.sv
tests/au_subsystem_asserts.sv
tests/tb_au_subsystem.sv

// ==== tests/au_subsystem_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on slot order, pipeline latency, APB wait
// states and the write enable of the arithmetic subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module au_subsystem_asserts
  import slice_pkg::*;
(
  input logic   CLK,
  input logic   RST,
  input logic   op_vld,
  input slice_t slice,
  input logic   result_vld,
  input logic   result_wr,
  input logic   rt_wr,
  input slice_t result_slice,
  input logic   pready
);

  // Slot counter steps once per clock and wraps
  a_slice_step: assert property (@(posedge CLK) disable iff (RST)
    1'b1 |=> (slice == slice_t'($past(slice) + 1)))
    else $error("slice did not advance by one");

  a_issue_to_result: assert property (@(posedge CLK) disable iff (RST)
    op_vld |-> ##2 (result_vld && (result_slice == $past(slice, 2))))
    else $error("operation did not retire two cycles after issue");

  a_result_from_issue: assert property (@(posedge CLK) disable iff (RST)
    result_vld |-> $past(op_vld, 2))
    else $error("result_vld without an operation two cycles earlier");

  // Wait states only come from a retire write and last one cycle
  a_stall_on_writeback: assert property (@(posedge CLK) disable iff (RST)
    !pready |-> result_wr ##1 pready)
    else $error("pready low without a write-back or for more than one cycle");

  // Execute marks a write only on a retiring operation
  a_wr_needs_vld: assert property (@(posedge CLK) disable iff (RST)
    (rt_wr || result_wr) |-> result_vld)
    else $error("result_wr high without result_vld");

endmodule

bind au_subsystem_top au_subsystem_asserts u_asserts (.*);

// ==== tests/tb_au_subsystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the arithmetic subsystem with clock and reset, APB
// tasks, random operation stimulus, reference model and result checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_au_subsystem
  import au_defs_pkg::*;
  import slice_pkg::*;
();

  localparam int DLY         = 10;
  localparam int N_MIX       = 256;
  localparam int N_BIT       = 128;
  localparam int N_FLAG      = 128;
  localparam int N_PAR       = 48;
  localparam int APB_XFERS   = 64 * 4 + 2 + 16 + 8;
  localparam int TOTAL_OPS   = N_MIX + N_BIT + N_FLAG + N_PAR;
  localparam int CYCLE_LIMIT = 2 * (APB_XFERS * 3 + TOTAL_OPS * 4 + 50);

  logic        CLK = 1'b0;
  logic        RST;
  logic        op_vld;
  au_op_t      op;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;
  slice_t      slice;
  au_flags_t   au_flags;
  logic        result_vld;
  logic        result_wr;
  slice_t      result_slice;
  reg_sel_t    result_reg;
  word_t       result_data;

  // Reference model state and the expected issue slot
  word_t       model_regs [RF_WORDS];
  au_flags_t   flag_model [NUM_SLICES];
  slice_t      slot;
  logic [41:0] exp_q [$];
  int          cyc_q [$];
  logic [41:0] exp_e;
  int          exp_cyc;
  int          cycle  = 0;
  int          errors = 0;
  int          stalls = 0;
  int          n_ops  = 0;
  integer      seed   = 32'h23b1_1ac6;

  au_subsystem_top dut0 (
    .CLK(CLK), .RST(RST), .op_vld(op_vld), .op(op), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .slice(slice), .au_flags(au_flags), .result_vld(result_vld),
    .result_wr(result_wr), .result_slice(result_slice), .result_reg(result_reg),
    .result_data(result_data)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK or posedge RST)
  begin
    if (RST)
      slot <= '0;
    else
      slot <= slot + 2'd1;
  end

  always @(posedge CLK)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("timeout: run stopped after %0d cycles, %0d errors", cycle, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    begin
      errors++;
      $display("error: %s got %h expected %h at time %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    begin
      errors++;
      $display("failure at time %0t: %s", $time, msg);
    end
  endtask

  // Expected {write, destination, flags, data} of one operation
  function automatic logic [39:0] ref_op(input au_op_t o, input slice_t s);
    word_t       a;
    word_t       b;
    logic [32:0] za;
    logic [32:0] wa;
    logic [32:0] r;
    logic [3:0]  cmd;
    logic [3:0]  dst;
    logic [4:0]  p;
    logic        wr;
    int          i;
    begin
      r   = '0;
      wr  = 1'b1;
      p   = o[8:4];
      dst = o[3:0];
      cmd = o[11:8];
      a   = model_regs[{s, o[3:0]}];
      b   = model_regs[{s, o[7:4]}];
      if (o[14:12] == 3'b001)
      begin
        a   = model_regs[{s, 1'b0, o[2:0]}];
        b   = model_regs[{s, 1'b0, o[5:3]}];
        dst = {1'b0, o[8:6]};
        cmd = {1'b0, o[11:9]};
      end
      za = {1'b0, a};
      wa = {a[31], a};
      if (o[14:13] == 2'b00)
      begin
        wr = (cmd != OP_CMP);
        // Logic operations keep a clear guard bit
        case (cmd)
          OP_OR:          r = {1'b0, a | b};
          OP_AND:         r = {1'b0, a & b};
          OP_XOR:         r = {1'b0, a ^ b};
          OP_ADD:         r = wa + {b[31], b};
          OP_SUB, OP_CMP: r = wa - {b[31], b};
          OP_MOV:         r = {b[31], b};
          OP_NOT:         r = ~{b[31], b};
          OP_NEG:         r = -{b[31], b};
          default:        r = '0;
        endcase
      end
      else if (o[14:12] == 3'b010)
      begin
        wr = (o[11:9] != BIT_TST);
        for (i = 0; i < 33; i++)
        begin
          case (o[11:9])
            BIT_SET:  r[i] = (i == p) || za[i];
            BIT_CLR:  r[i] = (i != p) && za[i];
            BIT_TST:  r[i] = (i == p) && za[i];
            BIT_SHL:  r[i] = (i >= p) ? za[i - p] : 1'b0;
            BIT_SHR:  r[i] = (i + p <= 32) ? za[i + p] : 1'b0;
            BIT_ASR:  r[i] = (i + p <= 32) ? wa[i + p] : a[31];
            BIT_SEXT: r[i] = (i >= p) ? a[p] : za[i];
            default:  r[i] = 1'b0;
          endcase
        end
      end
      else
      begin
        b  = o[14] ? {{23{o[12]}}, o[12:4]} : {{24{o[11]}}, o[11:4]};
        wr = (o[14:13] != IMM_CMP);
        case (o[14:13])
          IMM_ADD: r = wa + {b[31], b};
          IMM_CMP: r = wa - {b[31], b};
          default: r = {b[31], b};
        endcase
      end
      ref_op = {wr, dst, r[32] ^ r[31], r[31], (r[31:0] == 32'd0), r[31:0]};
    end
  endfunction

  // Kind 0 mixed, 1 bit and shift, 2 flag heavy, 3 short form only
  function automatic au_op_t pick_op(input int kind);
    logic [31:0] r;
    reg_sel_t    ra;
    reg_sel_t    rb;
    begin
      r  = $random(seed);
      ra = reg_sel_t'(r[7:4] % 12);
      rb = {2'b11, r[9:8]};
      pick_op = {3'b010, r[11:0]};
      if (kind == 0)
      begin
        case (r[31:30])
          2'd0:    pick_op = {3'b000, r[11:0]};
          2'd1:    pick_op = {3'b001, r[11:0]};
          2'd2:    pick_op = {3'b011, r[11:0]};
          default: pick_op = {1'b1, r[13:0]};
        endcase
      end
      else if (kind == 2)
      begin
        // Registers 12 to 15 hold the overflow corner values
        case (r[30:28])
          3'd0:    pick_op = {3'b000, OP_ADD, rb, ra};
          3'd1:    pick_op = {3'b000, OP_SUB, rb, ra};
          3'd2:    pick_op = {3'b000, OP_CMP, rb, ra};
          3'd3:    pick_op = {3'b000, OP_NEG, rb, ra};
          3'd4:    pick_op = {3'b010, BIT_TST, r[16:12], ra};
          3'd5:    pick_op = {2'b10, r[20:12], ra};
          3'd6:    pick_op = {3'b011, r[19:12], ra};
          default: pick_op = {3'b000, OP_CMP, ra, rb};
        endcase
      end
      else if (kind == 3)
        pick_op = {3'b001, r[11:0]};
    end
  endfunction

  function automatic apb_addr_t word_addr(input int idx);
    word_addr = apb_addr_t'(idx * 4);
  endfunction

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    logic done;
    int   waits;
    begin
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge CLK);
      #DLY;
      penable = 1'b1;
      done    = 1'b0;
      waits   = 0;
      while (!done)
      begin
        @(negedge CLK);
        done  = pready;
        rdata = prdata;
        err   = pslverr;
        waits++;
        @(posedge CLK);
        #DLY;
      end
      if (waits > 1)
        stalls++;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input word_t data);
    word_t rd;
    logic  err;
    begin
      apb_xfer(1'b1, addr, data, rd, err);
      assert (!err) else report_failure("APB write to a valid address returned pslverr");
      model_regs[addr[7:2]] = data;
    end
  endtask

  task automatic apb_read_check(input apb_addr_t addr);
    word_t rd;
    logic  err;
    begin
      apb_xfer(1'b0, addr, '0, rd, err);
      assert (!err) else report_failure("APB read of a valid address returned pslverr");
      assert (rd == model_regs[addr[7:2]])
        else report_mismatch("prdata", rd, model_regs[addr[7:2]]);
    end
  endtask

  task automatic check_addr_error(input logic wr, input apb_addr_t addr);
    word_t rd;
    logic  err;
    begin
      apb_xfer(wr, addr, 32'hdead_beef, rd, err);
      assert (err == 1'b1) else report_mismatch("pslverr", err, 1);
    end
  endtask

  task automatic readback_all();
    begin
      for (int i = 0; i < RF_WORDS; i++)
        apb_read_check(word_addr(i));
    end
  endtask

  task automatic issue_op(input au_op_t o);
    logic [39:0] r;
    begin
      r = ref_op(o, slot);
      exp_q.push_back({slot, r});
      cyc_q.push_back(cycle);
      if (r[39])
        model_regs[{slot, r[38:35]}] = r[31:0];
      op_vld = 1'b1;
      op     = o;
      n_ops++;
      @(posedge CLK);
      #DLY;
      op_vld = 1'b0;
    end
  endtask

  // Waits until every issued operation has retired
  task automatic drain();
    begin
      while (exp_q.size() != 0)
        @(posedge CLK);
      @(posedge CLK);
      #DLY;
    end
  endtask

  task automatic run_ops(input int n, input int kind);
    begin
      for (int k = 0; k < n; k++)
        issue_op(pick_op(kind));
      drain();
    end
  endtask

  // Short-form ops own registers 0 to 7 so the host writes the upper ones
  task automatic host_writes_during_retire();
    begin
      for (int k = 0; k < 8; k++)
        apb_write(word_addr((k % 4) * 16 + 8 + k), $random(seed));
    end
  endtask

  always @(negedge CLK)
  begin
    if (!RST)
    begin
      assert (slice == slot)
        else report_mismatch("slice", slice, slot);
      assert (au_flags == flag_model[slot])
        else report_mismatch("au_flags", au_flags, flag_model[slot]);
      assert (!result_vld || exp_q.size() != 0)
        else report_failure("result_vld high with no operation outstanding");
      if (result_vld && exp_q.size() != 0)
      begin
        exp_e   = exp_q.pop_front();
        exp_cyc = cyc_q.pop_front();
        assert (cycle - exp_cyc == 2)
          else report_failure("result did not appear two cycles after issue");
        assert (result_slice == exp_e[41:40])
          else report_mismatch("result_slice", result_slice, exp_e[41:40]);
        assert (result_reg == exp_e[38:35])
          else report_mismatch("result_reg", result_reg, exp_e[38:35]);
        assert (result_wr == exp_e[39])
          else report_mismatch("result_wr", result_wr, exp_e[39]);
        assert (result_data == exp_e[31:0])
          else report_mismatch("result_data", result_data, exp_e[31:0]);
        flag_model[exp_e[41:40]] = exp_e[34:32];
      end
    end
  end

  initial
  begin
    RST     = 1'b1;
    op_vld  = 1'b0;
    op      = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    foreach (model_regs[i])
      model_regs[i] = '0;
    foreach (flag_model[i])
      flag_model[i] = '0;
    repeat (3) @(posedge CLK);
    #DLY;
    RST = 1'b0;

    readback_all();
    for (int i = 0; i < RF_WORDS; i++)
      apb_write(word_addr(i), $random(seed));
    readback_all();
    check_addr_error(1'b0, 12'h100);
    check_addr_error(1'b1, 12'h1f0);

    run_ops(N_MIX, 0);
    run_ops(N_BIT, 1);
    for (int s = 0; s < NUM_SLICES; s++)
    begin
      apb_write(word_addr(s * 16 + 12), 32'h7fff_ffff);
      apb_write(word_addr(s * 16 + 13), 32'h8000_0000);
      apb_write(word_addr(s * 16 + 14), 32'h0000_0001);
      apb_write(word_addr(s * 16 + 15), 32'hffff_ffff);
    end
    run_ops(N_FLAG, 2);

    // Back-to-back retires while the host writes
    fork
      run_ops(N_PAR, 3);
      host_writes_during_retire();
    join
    assert (stalls > 0) else report_failure("no APB write was held by a retire write");
    readback_all();

    $display("done: %0d operations, %0d APB stalls, %0d errors", n_ops, stalls, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog/au_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage: operation word split, operand select and the
// registered operands for the execute stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module au_decode
  import au_defs_pkg::*;
  import slice_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       op_vld,
  input  au_op_t     op,
  input  slice_t     slice,
  input  word_t      ra_data,
  input  word_t      rb_data,
  output reg_sel_t   ra_sel,
  output reg_sel_t   rb_sel,
  output logic       ex_vld,
  output au_class_t  ex_class,
  output logic [3:0] ex_cmd,
  output word_t      ex_a,
  output word_t      ex_b,
  output reg_sel_t   ex_dst,
  output slice_t     ex_slice,
  output logic       ex_wr
);

  au_class_t  dec_class;
  logic       short_form;
  logic [3:0] dec_cmd;
  reg_sel_t   dec_dst;
  word_t      dec_b;
  logic       dec_cmp;

  // Short two-register form packs three 3-bit register fields
  assign short_form = (op[14:12] == 3'b001);

  assign ra_sel  = short_form ? {1'b0, op[2:0]} : op[3:0];
  assign rb_sel  = short_form ? {1'b0, op[5:3]} : op[7:4];
  assign dec_dst = short_form ? {1'b0, op[8:6]} : op[3:0];

  always_comb
  begin
    dec_class = class_none;
    dec_cmd   = '0;
    dec_b     = rb_data;
    if (op_vld)
    begin
      if (op[14:13] == 2'b00)
      begin
        dec_class = class_tworeg;
        dec_cmd   = short_form ? {1'b0, op[11:9]} : op[11:8];
      end
      else if (op[14:12] == 3'b010)
      begin
        // Bit command and position travel in operand b
        dec_class = class_bitop;
        dec_cmd   = {1'b0, op[11:9]};
        dec_b     = {24'd0, op[11:9], op[8:4]};
      end
      else
      begin
        dec_class = class_imm;
        dec_cmd   = {2'b00, op[14:13]};
        // 9-bit constant when bit 14 is set, 8-bit otherwise
        dec_b     = op[14] ? {{23{op[12]}}, op[12:4]} : {{24{op[11]}}, op[11:4]};
      end
    end
  end

  // Compares and bit test only touch the flags
  assign dec_cmp = ((dec_class == class_tworeg) && (dec_cmd == OP_CMP)) ||
                   ((dec_class == class_bitop) && (dec_cmd[2:0] == BIT_TST)) ||
                   ((dec_class == class_imm) && (dec_cmd[1:0] == IMM_CMP));

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ex_vld <= 1'b0;
      ex_wr  <= 1'b0;
    end
    else
    begin
      ex_vld <= op_vld;
      ex_wr  <= op_vld && !dec_cmp;
    end
  end

  always_ff @(posedge CLK)
  begin
    ex_class <= dec_class;
    if (op_vld)
    begin
      ex_cmd   <= dec_cmd;
      ex_a     <= ra_data;
      ex_b     <= dec_b;
      ex_dst   <= dec_dst;
      ex_slice <= slice;
    end
  end

endmodule

// ==== verilog/au_defs_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic unit definitions: data and operation word types,
// operation classes, flag bit positions and operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package au_defs_pkg;

  typedef logic [31:0] word_t;
  // Bit 32 is the sign guard used for overflow detection
  typedef logic [32:0] wide_t;
  typedef logic [14:0] au_op_t;
  typedef logic [3:0]  reg_sel_t;
  typedef logic [2:0]  au_flags_t;

  typedef enum logic [1:0] {
    class_none,
    class_tworeg,
    class_bitop,
    class_imm
  } au_class_t;

  // Positions inside au_flags_t
  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 2;

  // Two-register commands
  localparam logic [3:0] OP_OR  = 4'h0;
  localparam logic [3:0] OP_AND = 4'h1;
  localparam logic [3:0] OP_XOR = 4'h2;
  localparam logic [3:0] OP_ADD = 4'h3;
  localparam logic [3:0] OP_SUB = 4'h4;
  localparam logic [3:0] OP_MOV = 4'h8;
  localparam logic [3:0] OP_NOT = 4'h9;
  localparam logic [3:0] OP_NEG = 4'hA;
  localparam logic [3:0] OP_CMP = 4'hB;

  // Bit and shift commands, position in a 5-bit field
  localparam logic [2:0] BIT_SET  = 3'd0;
  localparam logic [2:0] BIT_CLR  = 3'd1;
  localparam logic [2:0] BIT_TST  = 3'd2;
  localparam logic [2:0] BIT_SHL  = 3'd4;
  localparam logic [2:0] BIT_SHR  = 3'd5;
  localparam logic [2:0] BIT_ASR  = 3'd6;
  localparam logic [2:0] BIT_SEXT = 3'd7;

  // Immediate commands
  localparam logic [1:0] IMM_ADD = 2'd1;
  localparam logic [1:0] IMM_CMP = 2'd2;
  localparam logic [1:0] IMM_LD  = 2'd3;

endpackage

// ==== verilog/au_execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage: 33-bit result of two-register, bit/shift and
// immediate operations, registered with the retire tags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module au_execute
  import au_defs_pkg::*;
  import slice_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       ex_vld,
  input  au_class_t  ex_class,
  input  logic [3:0] ex_cmd,
  input  word_t      ex_a,
  input  word_t      ex_b,
  input  reg_sel_t   ex_dst,
  input  slice_t     ex_slice,
  input  logic       ex_wr,
  output logic       rt_vld,
  output wide_t      rt_result,
  output reg_sel_t   rt_dst,
  output slice_t     rt_slice,
  output logic       rt_wr
);

  wide_t      a_w;
  wide_t      b_w;
  wide_t      a_z;
  logic [4:0] pos;
  wide_t      bit_mask;
  wide_t      ext_mask;
  wide_t      result;

  // Sign guarded and zero extended views of the operands
  assign a_w = {ex_a[31], ex_a};
  assign b_w = {ex_b[31], ex_b};
  assign a_z = {1'b0, ex_a};

  assign pos      = ex_b[4:0];
  assign bit_mask = wide_t'(1) << pos;
  // Ones from the selected bit upward, for sign-extend
  assign ext_mask = {33{1'b1}} << pos;

  always_comb
  begin
    result = '0;
    case (ex_class)
      class_tworeg:
        case (ex_cmd)
          OP_OR:   result = a_z | {1'b0, ex_b};
          OP_AND:  result = a_z & {1'b0, ex_b};
          OP_XOR:  result = a_z ^ {1'b0, ex_b};
          OP_ADD:  result = a_w + b_w;
          OP_SUB:  result = a_w - b_w;
          OP_MOV:  result = b_w;
          OP_NOT:  result = ~b_w;
          OP_NEG:  result = wide_t'(0) - b_w;
          OP_CMP:  result = a_w - b_w;
          default: result = '0;
        endcase
      class_bitop:
        case (ex_cmd[2:0])
          BIT_SET:  result = a_z | bit_mask;
          BIT_CLR:  result = a_z & ~bit_mask;
          BIT_TST:  result = a_z & bit_mask;
          BIT_SHL:  result = a_z << pos;
          BIT_SHR:  result = a_z >> pos;
          BIT_ASR:  result = wide_t'($signed(a_w) >>> pos);
          BIT_SEXT: result = ex_a[pos] ? (a_z | ext_mask) : (a_z & ~ext_mask);
          default:  result = '0;
        endcase
      class_imm:
        case (ex_cmd[1:0])
          IMM_ADD: result = a_w + b_w;
          IMM_CMP: result = a_w - b_w;
          IMM_LD:  result = b_w;
          default: result = '0;
        endcase
      class_none: result = '0;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      rt_vld <= 1'b0;
      rt_wr  <= 1'b0;
    end
    else
    begin
      rt_vld <= ex_vld;
      rt_wr  <= ex_vld && ex_wr;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (ex_vld)
    begin
      rt_result <= result;
      rt_dst    <= ex_dst;
      rt_slice  <= ex_slice;
    end
  end

endmodule

// ==== verilog/au_retire.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Retire stage: register write port and per-slice flag storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module au_retire
  import au_defs_pkg::*;
  import slice_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      rt_vld,
  input  wide_t     rt_result,
  input  reg_sel_t  rt_dst,
  input  slice_t    rt_slice,
  input  logic      rt_wr,
  input  slice_t    slice,
  output logic      wr_en,
  output slice_t    wr_slice,
  output reg_sel_t  wr_sel,
  output word_t     wr_data,
  output au_flags_t au_flags
);

  au_flags_t flags_q [NUM_SLICES];
  au_flags_t new_flags;

  // Write port straight from the execute registers
  assign wr_en    = rt_vld && rt_wr;
  assign wr_slice = rt_slice;
  assign wr_sel   = rt_dst;
  assign wr_data  = rt_result[31:0];

  always_comb
  begin
    new_flags         = '0;
    new_flags[FLAG_Z] = (rt_result[31:0] == 32'd0);
    new_flags[FLAG_N] = rt_result[31];
    // Guard bit disagrees with the sign on signed overflow
    new_flags[FLAG_V] = rt_result[32] ^ rt_result[31];
  end

  // Compares update flags too, so only the valid is checked
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      flags_q <= '{default: '0};
    end
    else if (rt_vld)
    begin
      flags_q[rt_slice] <= new_flags;
    end
  end

  assign au_flags = flags_q[slice];

endmodule

// ==== verilog/au_subsystem_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arithmetic subsystem top: slot sequencer, three pipeline
// stages and the shared register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module au_subsystem_top
  import au_defs_pkg::*;
  import slice_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      op_vld,
  input  au_op_t    op,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  output word_t     prdata,
  output logic      pready,
  output logic      pslverr,
  output slice_t    slice,
  output au_flags_t au_flags,
  output logic      result_vld,
  output logic      result_wr,
  output slice_t    result_slice,
  output reg_sel_t  result_reg,
  output word_t     result_data
);

  reg_sel_t   ra_sel;
  reg_sel_t   rb_sel;
  word_t      ra_data;
  word_t      rb_data;

  // Decode to execute
  logic       ex_vld;
  au_class_t  ex_class;
  logic [3:0] ex_cmd;
  word_t      ex_a;
  word_t      ex_b;
  reg_sel_t   ex_dst;
  slice_t     ex_slice;
  logic       ex_wr;

  // Execute to retire
  wide_t      rt_result;
  reg_sel_t   rt_dst;
  slice_t     rt_slice;
  logic       rt_wr;

  slice_sequencer u_seq (.CLK(CLK), .RST(RST), .slice(slice));

  au_decode u_decode (
    .CLK(CLK), .RST(RST), .op_vld(op_vld), .op(op), .slice(slice),
    .ra_data(ra_data), .rb_data(rb_data), .ra_sel(ra_sel), .rb_sel(rb_sel),
    .ex_vld(ex_vld), .ex_class(ex_class), .ex_cmd(ex_cmd), .ex_a(ex_a),
    .ex_b(ex_b), .ex_dst(ex_dst), .ex_slice(ex_slice), .ex_wr(ex_wr)
  );

  au_execute u_execute (
    .CLK(CLK), .RST(RST), .ex_vld(ex_vld), .ex_class(ex_class), .ex_cmd(ex_cmd),
    .ex_a(ex_a), .ex_b(ex_b), .ex_dst(ex_dst), .ex_slice(ex_slice), .ex_wr(ex_wr),
    .rt_vld(result_vld), .rt_result(rt_result), .rt_dst(rt_dst),
    .rt_slice(rt_slice), .rt_wr(rt_wr)
  );

  // Write port doubles as the result outputs
  au_retire u_retire (
    .CLK(CLK), .RST(RST), .rt_vld(result_vld), .rt_result(rt_result),
    .rt_dst(rt_dst), .rt_slice(rt_slice), .rt_wr(rt_wr), .slice(slice),
    .wr_en(result_wr), .wr_slice(result_slice), .wr_sel(result_reg),
    .wr_data(result_data), .au_flags(au_flags)
  );

  slice_regfile u_regfile (
    .CLK(CLK), .RST(RST), .slice(slice), .ra_sel(ra_sel), .rb_sel(rb_sel),
    .wr_en(result_wr), .wr_slice(result_slice), .wr_sel(result_reg),
    .wr_data(result_data), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .ra_data(ra_data), .rb_data(rb_data),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

endmodule

// ==== verilog/slice_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slice definitions: slice numbering, register file geometry
// and the APB address map of the register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package slice_pkg;

  typedef logic [1:0] slice_t;

  localparam int NUM_SLICES     = 4;
  localparam int REGS_PER_SLICE = 16;
  localparam int RF_WORDS       = NUM_SLICES * REGS_PER_SLICE;

  // Flat register file index, slice in the upper bits
  typedef logic [5:0] rf_idx_t;

  // APB map: slice in paddr[7:6], register in paddr[5:2]
  typedef logic [11:0] apb_addr_t;
  localparam int        APB_SLICE_LSB  = 6;
  localparam int        APB_REG_LSB    = 2;
  localparam apb_addr_t APB_ADDR_LIMIT = 12'h100;

endpackage

// ==== verilog/slice_regfile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file for all slices: two operand reads, retire write
// port and an APB slave for host preload and readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module slice_regfile
  import au_defs_pkg::*;
  import slice_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  slice_t    slice,
  input  reg_sel_t  ra_sel,
  input  reg_sel_t  rb_sel,
  input  logic      wr_en,
  input  slice_t    wr_slice,
  input  reg_sel_t  wr_sel,
  input  word_t     wr_data,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  output word_t     ra_data,
  output word_t     rb_data,
  output word_t     prdata,
  output logic      pready,
  output logic      pslverr
);

  word_t   mem [RF_WORDS];
  rf_idx_t apb_idx;
  logic    apb_access;
  logic    addr_err;
  logic    stall;
  logic    stall_q;
  logic    apb_wr;

  assign ra_data = mem[{slice, ra_sel}];
  assign rb_data = mem[{slice, rb_sel}];

  assign apb_idx    = {paddr[APB_SLICE_LSB +: 2], paddr[APB_REG_LSB +: 4]};
  assign apb_access = psel && penable;
  assign addr_err   = (paddr >= APB_ADDR_LIMIT);

  // Host write meeting a retire write waits one cycle
  assign stall   = apb_access && pwrite && wr_en && !stall_q;
  assign pready  = !stall;
  assign pslverr = apb_access && addr_err;
  assign apb_wr  = apb_access && pwrite && pready && !addr_err;
  assign prdata  = (apb_access && !pwrite && !addr_err) ? mem[apb_idx] : '0;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      stall_q <= 1'b0;
    end
    else
    begin
      stall_q <= stall;
    end
  end

  // Retire write comes last so it wins on the same address
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      mem <= '{default: '0};
    end
    else
    begin
      if (apb_wr)
        mem[apb_idx] <= pwdata;
      if (wr_en)
        mem[{wr_slice, wr_sel}] <= wr_data;
    end
  end

endmodule

// ==== verilog/slice_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue slot counter, names the slice allowed to issue each cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module slice_sequencer
  import slice_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  output slice_t slice
);

  // Round robin over all slices, one step per clock
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      slice <= '0;
    end
    else if (slice == slice_t'(NUM_SLICES - 1))
    begin
      slice <= '0;
    end
    else
    begin
      slice <= slice + slice_t'(1);
    end
  end

endmodule
